//--- Bender.yml
package:
  name: exec_core

sources:
  - include_dirs:
      - include
    files:
      - verilog/instr_pkg.sv
      - verilog/exec_pkg.sv
      - verilog/inst_decode.sv
      - verilog/reg_file.sv
      - verilog/alu_exec.sv
      - verilog/exec_core.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_exec_core.sv

//--- include/alu_consts.svh
// execute slice constants: widths, RV32I opcodes, funct fields and ALU control codes
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// datapath and register file sizing
`define XLEN 32
`define NREGS 32
`define REG_AW 5
`define ALU_CW 4

// major opcodes handled by this slice
`define OPC_OP 7'b0110011
`define OPC_OP_IMM 7'b0010011
`define OPC_LUI 7'b0110111

// funct3 encodings shared by OP and OP-IMM
`define F3_ADD_SUB 3'b000
`define F3_SLL 3'b001
`define F3_SLT 3'b010
`define F3_SLTU 3'b011
`define F3_XOR 3'b100
`define F3_SRL_SRA 3'b101
`define F3_OR 3'b110
`define F3_AND 3'b111

// funct7, base form and the sub/sra alternate
`define F7_BASE 7'b0000000
`define F7_ALT 7'b0100000

// alu control codes
`define ALU_ADD 4'b0000
`define ALU_SUB 4'b0001
`define ALU_SLL 4'b0010
`define ALU_SLT 4'b0011
`define ALU_SLTU 4'b0100
`define ALU_XOR 4'b0101
`define ALU_SRL 4'b0110
`define ALU_SRA 4'b0111
`define ALU_OR 4'b1000
`define ALU_AND 4'b1001
// pass src2 through, used by lui
`define ALU_PASS 4'b1010
`define ALU_SRLI 4'b1011
`define ALU_SLLI 4'b1100
`define ALU_SRAI 4'b1101

`endif

//--- sim/tb_exec_core.sv
// execute slice testbench: directed instruction tests checked against a register model
`timescale 1ns/1ps
`include "alu_consts.svh"

module tb_exec_core;

	// tests run about 400 cycles, the limit leaves plenty of margin
	localparam int MAX_CYCLES = 2000;

	// one expected result and the cycle it must show up in
	typedef struct packed {
		logic [4:0] rd;
		logic [31:0] value;
		logic zero;
		logic [31:0] due;
	} exp_t;

	logic clk;
	logic rst_n;
	logic in_valid;
	logic [`XLEN-1:0] instr;
	exec_pkg::result_t result;
	logic illegal;

	logic [31:0] cycles = 32'd0;
	logic [`XLEN-1:0] model_regs [0:`NREGS-1];
	exp_t exp_q[$];
	logic [31:0] ill_q[$];

	exec_core uut (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.instr(instr),
		.result(result),
		.illegal(illegal)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("run timed out after %0d cycles", cycles);
			stop_run();
		end
	end

	task automatic stop_run();
		$display("Regression failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %0t %s: got %h, expected %h", $time, what, got, exp);
			stop_run();
		end
	endtask

	// reference behavior of one operation, straight from the RV32I rules
	function automatic logic [31:0] model_alu(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		logic [4:0] sh;
		logic [31:0] res;
		sh = b[4:0];
		case (f3)
			`F3_ADD_SUB: res = alt ? a - b : a + b;
			`F3_SLL: res = a << sh;
			`F3_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			`F3_SLTU: res = (a < b) ? 32'd1 : 32'd0;
			`F3_XOR: res = a ^ b;
			`F3_SRL_SRA: begin
				if (alt) begin
					res = $signed(a) >>> sh;
				end else begin
					res = a >> sh;
				end
			end
			`F3_OR: res = a | b;
			default: res = a & b;
		endcase
		return res;
	endfunction

	// one word on the input, expectation queued, model updated in program order
	task automatic send(input logic [31:0] word, input logic legal, input logic [4:0] rd,
			input logic [31:0] value);
		exp_t e;
		@(posedge clk);
		in_valid <= 1'b1;
		instr <= word;
		// dut samples at the next edge, the result is registered one edge later
		if (legal) begin
			e.rd = rd;
			e.value = value;
			e.zero = (value == 32'd0);
			e.due = cycles + 3;
			exp_q.push_back(e);
			if (rd != 5'd0) begin
				model_regs[rd] = value;
			end
		end else begin
			ill_q.push_back(cycles + 2);
		end
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			in_valid <= 1'b0;
		end
	endtask

	// wait until every queued expectation has been seen
	task automatic drain();
		idle(1);
		while (exp_q.size() != 0 || ill_q.size() != 0) begin
			idle(1);
		end
	endtask

	task automatic r_op(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
			input logic [4:0] rs1, input logic [4:0] rs2);
		logic [31:0] value;
		logic [6:0] f7;
		value = model_alu(f3, alt, model_regs[rs1], model_regs[rs2]);
		f7 = alt ? `F7_ALT : `F7_BASE;
		send({f7, rs2, rs1, f3, rd, `OPC_OP}, 1'b1, rd, value);
	endtask

	task automatic i_op(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
			input logic [11:0] imm);
		logic [31:0] b;
		logic alt;
		logic [31:0] value;
		b = {{20{imm[11]}}, imm};
		// srai carries its alternate bit at imm[10]
		alt = (f3 == `F3_SRL_SRA) && imm[10];
		value = model_alu(f3, alt, model_regs[rs1], b);
		send({imm, rs1, f3, rd, `OPC_OP_IMM}, 1'b1, rd, value);
	endtask

	task automatic lui_op(input logic [4:0] rd, input logic [19:0] imm20);
		send({imm20, rd, `OPC_LUI}, 1'b1, rd, {imm20, 12'b0});
	endtask

	// lui then a dependent addi, upper part rounded for the signed low half
	task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
		logic [31:0] hi;
		hi = (v + 32'h800) >> 12;
		lui_op(rd, hi[19:0]);
		i_op(`F3_ADD_SUB, rd, rd, v[11:0]);
	endtask

	task automatic all_r_ops(input logic [4:0] rs1, input logic [4:0] rs2);
		for (int i = 0; i < 8; i++) begin
			r_op(3'(i), 1'b0, 5'(20 + i), rs1, rs2);
		end
		r_op(`F3_ADD_SUB, 1'b1, 5'd28, rs1, rs2);
		r_op(`F3_SRL_SRA, 1'b1, 5'd29, rs1, rs2);
	endtask

	task automatic after_reset();
		repeat (4) begin
			@(negedge clk);
			check("result.valid after reset", result.valid, 32'd0);
			check("illegal after reset", illegal, 32'd0);
		end
		// x1..x5 get small constants
		for (int r = 1; r <= 5; r++) begin
			i_op(`F3_ADD_SUB, 5'(r), 5'd0, 12'(r * 3 + 1));
		end
		drain();
	endtask

	task automatic reg_ops();
		repeat (3) begin
			load_const(5'd6, $urandom);
			load_const(5'd7, $urandom);
			all_r_ops(5'd6, 5'd7);
		end
		// compares across the sign boundary, both orders
		load_const(5'd6, 32'h7fff_ffff);
		load_const(5'd7, 32'h8000_0000);
		all_r_ops(5'd6, 5'd7);
		all_r_ops(5'd7, 5'd6);
		// shift amount 3 with all upper bits set
		load_const(5'd6, 32'h8421_0f0f);
		load_const(5'd7, 32'hffff_ffe3);
		all_r_ops(5'd6, 5'd7);
		drain();
	endtask

	task automatic imm_ops();
		load_const(5'd9, 32'hf0f0_1234);
		i_op(`F3_ADD_SUB, 5'd10, 5'd9, 12'hffb);
		i_op(`F3_SLT, 5'd10, 5'd9, 12'hfff);
		i_op(`F3_SLTU, 5'd11, 5'd9, 12'hfff);
		i_op(`F3_SLT, 5'd11, 5'd0, 12'h800);
		i_op(`F3_SLTU, 5'd11, 5'd0, 12'h800);
		i_op(`F3_XOR, 5'd10, 5'd9, 12'hfff);
		i_op(`F3_OR, 5'd10, 5'd9, 12'hf00);
		i_op(`F3_AND, 5'd10, 5'd9, 12'hff0);
		i_op(`F3_SLL, 5'd10, 5'd9, 12'h007);
		i_op(`F3_SRL_SRA, 5'd10, 5'd9, 12'h009);
		i_op(`F3_SRL_SRA, 5'd10, 5'd9, 12'h40c);
		lui_op(5'd12, 20'habcde);
		lui_op(5'd12, 20'hfffff);
		i_op(`F3_ADD_SUB, 5'd13, 5'd12, 12'h000);
		drain();
	endtask

	task automatic forwarding_chains();
		// doubling chain, both sources bypassed each time
		i_op(`F3_ADD_SUB, 5'd14, 5'd0, 12'h003);
		repeat (4) begin
			r_op(`F3_ADD_SUB, 1'b0, 5'd14, 5'd14, 5'd14);
		end
		r_op(`F3_ADD_SUB, 1'b1, 5'd15, 5'd14, 5'd1);
		r_op(`F3_XOR, 1'b0, 5'd14, 5'd15, 5'd14);
		for (int gap = 1; gap <= 2; gap++) begin
			i_op(`F3_ADD_SUB, 5'd16, 5'd14, 12'h7ff);
			idle(gap);
			r_op(`F3_ADD_SUB, 1'b0, 5'd17, 5'd16, 5'd14);
			idle(gap);
			r_op(`F3_SLL, 1'b0, 5'd16, 5'd17, 5'd2);
		end
		drain();
	endtask

	task automatic x0_and_zero();
		// result still reports rd 0, the register stays zero
		i_op(`F3_ADD_SUB, 5'd0, 5'd0, 12'h037);
		r_op(`F3_ADD_SUB, 1'b0, 5'd18, 5'd0, 5'd0);
		i_op(`F3_ADD_SUB, 5'd0, 5'd5, 12'h001);
		idle(2);
		i_op(`F3_OR, 5'd19, 5'd0, 12'h000);
		r_op(`F3_ADD_SUB, 1'b1, 5'd20, 5'd5, 5'd5);
		r_op(`F3_ADD_SUB, 1'b1, 5'd21, 5'd5, 5'd4);
		drain();
	endtask

	task automatic illegal_insts();
		i_op(`F3_ADD_SUB, 5'd3, 5'd0, 12'h123);
		// branch opcode, mul funct7, alternate xor, alternate slli, all aimed at x3
		send({7'b0, 5'd1, 5'd2, 3'b000, 5'd3, 7'b1100011}, 1'b0, 5'd0, 32'd0);
		send({7'b0000001, 5'd1, 5'd2, `F3_ADD_SUB, 5'd3, `OPC_OP}, 1'b0, 5'd0, 32'd0);
		send({`F7_ALT, 5'd1, 5'd2, `F3_XOR, 5'd3, `OPC_OP}, 1'b0, 5'd0, 32'd0);
		send({`F7_ALT, 5'd4, 5'd2, `F3_SLL, 5'd3, `OPC_OP_IMM}, 1'b0, 5'd0, 32'd0);
		i_op(`F3_ADD_SUB, 5'd22, 5'd3, 12'h000);
		idle(3);
		i_op(`F3_ADD_SUB, 5'd22, 5'd3, 12'h000);
		drain();
	endtask

	// output monitor, sampled mid-cycle where outputs are settled
	always @(negedge clk) begin : watch
		exp_t e;
		logic [31:0] due;
		if (rst_n === 1'b1) begin
			if (result.valid === 1'b1) begin
				if (exp_q.size() == 0) begin
					$display("result for rd %0d appeared with nothing pending", result.rd);
					stop_run();
				end else begin
					e = exp_q.pop_front();
					check("result cycle", cycles, e.due);
					check("result rd", result.rd, e.rd);
					check("result value", result.value, e.value);
					check("result zero", result.zero, e.zero);
				end
			end else if (exp_q.size() != 0) begin
				e = exp_q[0];
				if (e.due <= cycles) begin
					$display("expected result for rd %0d did not appear", e.rd);
					stop_run();
				end
			end
			if (illegal === 1'b1) begin
				if (ill_q.size() == 0) begin
					$display("illegal pulse with no illegal instruction pending");
					stop_run();
				end else begin
					due = ill_q.pop_front();
					check("illegal cycle", cycles, due);
				end
			end else if (ill_q.size() != 0 && ill_q[0] <= cycles) begin
				$display("expected illegal pulse did not appear");
				stop_run();
			end
		end
	end

	initial begin
		rst_n = 1'b0;
		in_valid = 1'b0;
		instr = '0;
		void'($urandom(9));
		for (int r = 0; r < `NREGS; r++) begin
			model_regs[r] = '0;
		end
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		after_reset();
		reg_ops();
		imm_ops();
		forwarding_chains();
		x0_and_zero();
		illegal_insts();
		if (exp_q.size() == 0 && ill_q.size() == 0) begin
			$display("Regression passed");
			$finish;
		end else begin
			$display("expected outputs still pending at the end of the run");
			stop_run();
		end
	end

endmodule

//--- sources.f
+incdir+include
verilog/instr_pkg.sv
verilog/exec_pkg.sv
verilog/inst_decode.sv
verilog/reg_file.sv
verilog/alu_exec.sv
verilog/exec_core.sv
sim/tb_exec_core.sv

//--- verilog/alu_exec.sv
// alu stage: computes the operation, drives write-back and registers the result with zero flag
`timescale 1ns/1ps
`include "alu_consts.svh"

module alu_exec (
	input logic clk,
	input logic rst_n,
	input exec_pkg::issue_t issue,
	output exec_pkg::wb_t wb,
	output exec_pkg::result_t result
);

	logic [`XLEN-1:0] a;
	logic [`XLEN-1:0] b;
	logic [4:0] shamt;
	logic [`XLEN:0] diff;
	logic lt_u;
	logic lt_s;
	logic ovf;
	logic [`XLEN-1:0] value;

	assign a = issue.a;
	assign b = issue.b;
	// every shift uses only the low five bits
	assign shamt = b[4:0];

	// a - b as a + ~b + 1, carry out set means no borrow
	assign diff = {1'b0, a} + {1'b0, ~b} + {{`XLEN{1'b0}}, 1'b1};
	assign lt_u = ~diff[`XLEN];
	// signed overflow when operand signs differ and the difference flips sign
	assign ovf = (a[`XLEN-1] ^ b[`XLEN-1]) & (diff[`XLEN-1] ^ a[`XLEN-1]);
	assign lt_s = diff[`XLEN-1] ^ ovf;

	always_comb begin
		case (issue.alu_ctrl)
			`ALU_ADD: value = a + b;
			`ALU_SUB: value = diff[`XLEN-1:0];
			`ALU_SLL: value = a << shamt;
			`ALU_SLT: value = {{(`XLEN-1){1'b0}}, lt_s};
			`ALU_SLTU: value = {{(`XLEN-1){1'b0}}, lt_u};
			`ALU_XOR: value = a ^ b;
			`ALU_SRL: value = a >> shamt;
			`ALU_SRA: value = $signed(a) >>> shamt;
			`ALU_OR: value = a | b;
			`ALU_AND: value = a & b;
			`ALU_PASS: value = b;
			`ALU_SRLI: value = a >> shamt;
			`ALU_SLLI: value = a << shamt;
			`ALU_SRAI: value = $signed(a) >>> shamt;
			default: value = '0;
		endcase
	end

	// write-back straight from the issue register, committed at the next edge
	assign wb.we = issue.valid;
	assign wb.rd = issue.rd;
	assign wb.data = value;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			result.valid <= 1'b0;
		end else begin
			result.valid <= issue.valid;
		end
	end

	// result payload, same edge as the regfile write
	always_ff @(posedge clk) begin
		if (issue.valid) begin
			result.rd <= issue.rd;
			result.value <= value;
			result.zero <= (value == '0);
		end
	end

endmodule

//--- verilog/exec_core.sv
// execute slice top: decoder, register file and alu in a two-stage pipeline
`timescale 1ns/1ps
`include "alu_consts.svh"

module exec_core (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input logic [`XLEN-1:0] instr,
	output exec_pkg::result_t result,
	output logic illegal
);

	logic [`REG_AW-1:0] rs1_addr;
	logic [`REG_AW-1:0] rs2_addr;
	logic [`XLEN-1:0] rs1_data;
	logic [`XLEN-1:0] rs2_data;
	exec_pkg::issue_t issue;
	// write-back fans out to the regfile and the decode bypass
	exec_pkg::wb_t wb;

	// stage 1, decode and operand read
	inst_decode u_decode (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.instr(instr_pkg::instr_u'(instr)),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.wb(wb),
		.rs1_addr(rs1_addr),
		.rs2_addr(rs2_addr),
		.issue(issue),
		.illegal(illegal)
	);

	reg_file u_regs (
		.clk(clk),
		.rst_n(rst_n),
		.rs1_addr(rs1_addr),
		.rs2_addr(rs2_addr),
		.wb(wb),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data)
	);

	// stage 2, execute and write back
	alu_exec u_alu (
		.clk(clk),
		.rst_n(rst_n),
		.issue(issue),
		.wb(wb),
		.result(result)
	);

endmodule

//--- verilog/exec_pkg.sv
// execute-stage types passed between decode, register file and ALU
`include "alu_consts.svh"

package exec_pkg;

	// decoded operation, operands already resolved
	typedef struct packed {
		logic valid;
		logic [`ALU_CW-1:0] alu_ctrl;
		logic [`REG_AW-1:0] rd;
		logic [`XLEN-1:0] a;
		logic [`XLEN-1:0] b;
	} issue_t;

	// write-back port, also the forwarding source for decode
	typedef struct packed {
		logic we;
		logic [`REG_AW-1:0] rd;
		logic [`XLEN-1:0] data;
	} wb_t;

	// registered result at the top level
	typedef struct packed {
		logic valid;
		logic [`REG_AW-1:0] rd;
		logic [`XLEN-1:0] value;
		// high when value is all zeros
		logic zero;
	} result_t;

endpackage

//--- verilog/inst_decode.sv
// instruction decoder: selects alu control, resolves operands with forwarding, registers issue
`timescale 1ns/1ps
`include "alu_consts.svh"

module inst_decode (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input instr_pkg::instr_u instr,
	input logic [`XLEN-1:0] rs1_data,
	input logic [`XLEN-1:0] rs2_data,
	input exec_pkg::wb_t wb,
	output logic [`REG_AW-1:0] rs1_addr,
	output logic [`REG_AW-1:0] rs2_addr,
	output exec_pkg::issue_t issue,
	output logic illegal
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [`XLEN-1:0] imm_sext;
	logic [`XLEN-1:0] src1;
	logic [`XLEN-1:0] src2;
	logic [`ALU_CW-1:0] ctrl;
	logic [`XLEN-1:0] op_a;
	logic [`XLEN-1:0] op_b;
	logic legal;

	// field extraction, funct7 via R view and the immediate via I view
	assign opcode = instr.i.opcode;
	assign funct3 = instr.r.funct3;
	assign funct7 = instr.r.funct7;
	assign imm_sext = {{(`XLEN-12){instr.i.imm[11]}}, instr.i.imm};
	assign rs1_addr = instr.r.rs1;
	assign rs2_addr = instr.r.rs2;

	// bypass the result sitting in the alu stage
	// x0 never forwards, the regfile already reads it as zero
	assign src1 = (wb.we && wb.rd == rs1_addr && wb.rd != '0) ? wb.data : rs1_data;
	assign src2 = (wb.we && wb.rd == rs2_addr && wb.rd != '0) ? wb.data : rs2_data;

	always_comb begin
		ctrl = `ALU_ADD;
		op_a = src1;
		op_b = src2;
		legal = 1'b1;
		case (opcode)
			`OPC_OP: begin
				case (funct3)
					`F3_ADD_SUB: ctrl = (funct7 == `F7_ALT) ? `ALU_SUB : `ALU_ADD;
					`F3_SLL: ctrl = `ALU_SLL;
					`F3_SLT: ctrl = `ALU_SLT;
					`F3_SLTU: ctrl = `ALU_SLTU;
					`F3_XOR: ctrl = `ALU_XOR;
					`F3_SRL_SRA: ctrl = (funct7 == `F7_ALT) ? `ALU_SRA : `ALU_SRL;
					`F3_OR: ctrl = `ALU_OR;
					default: ctrl = `ALU_AND;
				endcase
				// only add/sub and srl/sra have an alternate form
				if (funct7 != `F7_BASE) begin
					legal = (funct7 == `F7_ALT) &&
						(funct3 == `F3_ADD_SUB || funct3 == `F3_SRL_SRA);
				end
			end
			`OPC_OP_IMM: begin
				op_b = imm_sext;
				case (funct3)
					`F3_ADD_SUB: ctrl = `ALU_ADD;
					`F3_SLL: begin
						ctrl = `ALU_SLLI;
						legal = (funct7 == `F7_BASE);
					end
					`F3_SLT: ctrl = `ALU_SLT;
					`F3_SLTU: ctrl = `ALU_SLTU;
					`F3_XOR: ctrl = `ALU_XOR;
					`F3_SRL_SRA: begin
						ctrl = (funct7 == `F7_ALT) ? `ALU_SRAI : `ALU_SRLI;
						legal = (funct7 == `F7_BASE) || (funct7 == `F7_ALT);
					end
					`F3_OR: ctrl = `ALU_OR;
					default: ctrl = `ALU_AND;
				endcase
			end
			`OPC_LUI: begin
				// upper immediate straight through the alu
				ctrl = `ALU_PASS;
				op_a = '0;
				op_b = {instr.raw[31:12], 12'b0};
			end
			default: legal = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			issue.valid <= 1'b0;
			illegal <= 1'b0;
		end else begin
			issue.valid <= in_valid && legal;
			// one-cycle pulse, nothing is issued for it
			illegal <= in_valid && !legal;
		end
	end

	// payload, loaded on every accepted word
	always_ff @(posedge clk) begin
		if (in_valid) begin
			issue.alu_ctrl <= ctrl;
			issue.rd <= instr.i.rd;
			issue.a <= op_a;
			issue.b <= op_b;
		end
	end

endmodule

//--- verilog/instr_pkg.sv
// instruction format types for the RV32I execute slice, R and I views of one word
`include "alu_consts.svh"

package instr_pkg;

	// register-register layout
	typedef struct packed {
		logic [6:0] funct7;
		logic [`REG_AW-1:0] rs2;
		logic [`REG_AW-1:0] rs1;
		logic [2:0] funct3;
		logic [`REG_AW-1:0] rd;
		logic [6:0] opcode;
	} r_type_t;

	// register-immediate layout
	// imm[4:0] doubles as shamt, imm[11:5] as the shift funct7
	typedef struct packed {
		logic [11:0] imm;
		logic [`REG_AW-1:0] rs1;
		logic [2:0] funct3;
		logic [`REG_AW-1:0] rd;
		logic [6:0] opcode;
	} i_type_t;

	// one fetched word, decoded either way
	// opcode, rd, rs1 and funct3 sit at the same bits in both views
	typedef union packed {
		logic [`XLEN-1:0] raw;
		r_type_t r;
		i_type_t i;
	} instr_u;

endpackage

//--- verilog/reg_file.sv
// architectural register file: x0 reads zero, two async reads, one clocked write
`timescale 1ns/1ps
`include "alu_consts.svh"

module reg_file (
	input logic clk,
	input logic rst_n,
	input logic [`REG_AW-1:0] rs1_addr,
	input logic [`REG_AW-1:0] rs2_addr,
	input exec_pkg::wb_t wb,
	output logic [`XLEN-1:0] rs1_data,
	output logic [`XLEN-1:0] rs2_data
);

	// x1..x31 only, x0 has no storage
	logic [`XLEN-1:0] regs [1:`NREGS-1];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			// all architectural state starts at zero
			for (int i = 1; i < `NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.we && wb.rd != '0) begin
			// writes aimed at x0 are dropped here
			regs[wb.rd] <= wb.data;
		end
	end

	// combinational reads
	// a same-cycle write is not visible, decode forwards it instead
	always_comb begin
		rs1_data = '0;
		rs2_data = '0;
		if (rs1_addr != '0) begin
			rs1_data = regs[rs1_addr];
		end
		if (rs2_addr != '0) begin
			rs2_data = regs[rs2_addr];
		end
	end

endmodule
